// File: hw/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// widths fixed by the ISA
`define RV_XLEN  32
`define RV_NREGS 32

// major opcodes handled here
`define RV_OPC_OP     7'h33
`define RV_OPC_OPIMM  7'h13
`define RV_OPC_LUI    7'h37
`define RV_OPC_BRANCH 7'h63

// alu operation codes
`define RV_ALU_ADD   4'd0
`define RV_ALU_SUB   4'd1
`define RV_ALU_XOR   4'd2
`define RV_ALU_OR    4'd3
`define RV_ALU_AND   4'd4
`define RV_ALU_SLL   4'd5
`define RV_ALU_SRL   4'd6
`define RV_ALU_SRA   4'd7
`define RV_ALU_SLT   4'd8
`define RV_ALU_SLTU  4'd9
`define RV_ALU_PASSB 4'd10

`endif

// File: hw/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]          word_t;     // data and instruction word
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t; // x0..x31
  typedef logic [3:0]                   alu_op_t;   // RV_ALU_* values
  typedef logic [2:0]                   funct3_t;

  // handshake sequencing
  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK
  } ctrl_state_e;

endpackage

// File: hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder (
  input  logic              clk,
  input  logic              rst,
  input  logic              capture,
  input  rv_pkg::word_t     instr,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              use_imm,
  output logic              rd_we,
  output logic              is_branch,
  output rv_pkg::funct3_t   br_funct3,
  output logic              illegal
);

  logic [6:0]      opcode;
  rv_pkg::funct3_t funct3;
  logic [6:0]      funct7;
  logic            is_r;
  logic            is_i;
  logic            is_u;
  logic            is_b;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_d;
  rv_pkg::alu_op_t alu_op_d;
  rv_pkg::alu_op_t base_op;
  logic            use_imm_d;
  logic            rd_we_d;
  logic            illegal_d;

  ////////////////////
  // field split and form detect

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign is_r = (opcode == `RV_OPC_OP);
  assign is_i = (opcode == `RV_OPC_OPIMM);
  assign is_u = (opcode == `RV_OPC_LUI);
  assign is_b = (opcode == `RV_OPC_BRANCH);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};                 // upper 20 bits over 12 zero bits
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7],
                  instr[30:25], instr[11:8], 1'b0};     // offset unused without a pc

  // funct3 to op for both R and I forms
  always_comb begin
    case (funct3)
      3'h0:    base_op = `RV_ALU_ADD;
      3'h1:    base_op = `RV_ALU_SLL;
      3'h2:    base_op = `RV_ALU_SLT;
      3'h3:    base_op = `RV_ALU_SLTU;
      3'h4:    base_op = `RV_ALU_XOR;
      3'h5:    base_op = `RV_ALU_SRL;
      3'h6:    base_op = `RV_ALU_OR;
      default: base_op = `RV_ALU_AND;
    endcase
  end

  ////////////////////
  // op select and legality

  always_comb begin
    alu_op_d  = `RV_ALU_ADD;
    use_imm_d = 1'b0;
    imm_d     = '0;
    illegal_d = 1'b0;
    if (is_r) begin
      alu_op_d = base_op;
      if (funct7 == 7'h20) begin
        if (funct3 == 3'h0) begin
          alu_op_d = `RV_ALU_SUB;
        end else if (funct3 == 3'h5) begin
          alu_op_d = `RV_ALU_SRA;
        end else begin
          illegal_d = 1'b1;                             // no alt form for this funct3
        end
      end else if (funct7 != 7'h00) begin
        illegal_d = 1'b1;
      end
    end else if (is_i) begin
      alu_op_d  = base_op;
      use_imm_d = 1'b1;
      imm_d     = imm_i;
      if (funct3 == 3'h1) begin
        illegal_d = (imm_i[11:5] != 7'h00);             // slli
      end else if (funct3 == 3'h5) begin
        if (imm_i[11:5] == 7'h20) begin
          alu_op_d = `RV_ALU_SRA;                       // srai
        end else if (imm_i[11:5] != 7'h00) begin
          illegal_d = 1'b1;
        end
      end
    end else if (is_u) begin
      alu_op_d  = `RV_ALU_PASSB;
      use_imm_d = 1'b1;
      imm_d     = imm_u;
    end else if (is_b) begin
      imm_d     = imm_b;
      illegal_d = (funct3 == 3'h2) || (funct3 == 3'h3); // reserved branch codes
    end else begin
      illegal_d = 1'b1;                                 // opcode not supported
    end
  end

  assign rd_we_d = (is_r || is_i || is_u) && !illegal_d;

  ////////////////////
  // capture registers

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_op    <= `RV_ALU_ADD;
      use_imm   <= 1'b0;
      rd_we     <= 1'b0;
      is_branch <= 1'b0;
      illegal   <= 1'b0;
    end else if (capture) begin
      alu_op    <= alu_op_d;
      use_imm   <= use_imm_d;
      rd_we     <= rd_we_d;
      is_branch <= is_b;
      illegal   <= illegal_d;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rs1       <= instr[19:15];
      rs2       <= instr[24:20];
      rd        <= instr[11:7];
      imm       <= imm_d;
      br_funct3 <= funct3;
    end
  end

  a_illegal_no_write : assert property (
    @(posedge clk) disable iff (rst)
    capture |=> $onehot({rd_we, is_branch && !illegal, illegal})
  ) else $error("decoded instruction is not exactly one of write, branch or illegal");

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);

  rv_pkg::word_t regs [`RV_NREGS];

  // async read, x0 stays zero since it is never written
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin // drop x0 writes
      regs[waddr] <= wdata;
    end
  end

  a_x0_zero_p1 : assert property (
    @(posedge clk) disable iff (rst) (raddr1 == '0) |-> (rdata1 == '0)
  ) else $error("x0 read nonzero on port 1");

  a_x0_zero_p2 : assert property (
    @(posedge clk) disable iff (rst) (raddr2 == '0) |-> (rdata2 == '0)
  ) else $error("x0 read nonzero on port 2");

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu (
  input  rv_pkg::alu_op_t alu_op,
  input  logic            use_imm,
  input  rv_pkg::word_t   rd1,
  input  rv_pkg::word_t   rd2,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::funct3_t br_funct3,
  output rv_pkg::word_t   result,
  output logic            taken
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;
  logic          cmp_lt_s;
  logic          cmp_lt_u;
  logic          cmp_eq;

  assign op_b  = use_imm ? imm : rd2;
  assign shamt = op_b[4:0];                     // rv32 shifts use low 5 bits

  assign lt_s = ($signed(rd1) < $signed(op_b));
  assign lt_u = (rd1 < op_b);

  ////////////////////
  // arithmetic, logic, shift

  always_comb begin
    case (alu_op)
      `RV_ALU_ADD:   result = rd1 + op_b;
      `RV_ALU_SUB:   result = rd1 - op_b;
      `RV_ALU_XOR:   result = rd1 ^ op_b;
      `RV_ALU_OR:    result = rd1 | op_b;
      `RV_ALU_AND:   result = rd1 & op_b;
      `RV_ALU_SLL:   result = rd1 << shamt;
      `RV_ALU_SRL:   result = rd1 >> shamt;
      `RV_ALU_SRA:   result = $signed(rd1) >>> shamt; // sign fill
      `RV_ALU_SLT:   result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      `RV_ALU_SLTU:  result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      `RV_ALU_PASSB: result = op_b;                    // lui
      default:       result = '0;
    endcase
  end

  ////////////////////
  // branch condition, always register to register

  assign cmp_eq   = (rd1 == rd2);
  assign cmp_lt_s = ($signed(rd1) < $signed(rd2));
  assign cmp_lt_u = (rd1 < rd2);

  always_comb begin
    case (br_funct3)
      3'h0:    taken = cmp_eq;    // beq
      3'h1:    taken = !cmp_eq;   // bne
      3'h4:    taken = cmp_lt_s;  // blt
      3'h5:    taken = !cmp_lt_s; // bge
      3'h6:    taken = cmp_lt_u;  // bltu
      3'h7:    taken = !cmp_lt_u; // bgeu
      default: taken = 1'b0;      // reserved, decoder flags illegal
    endcase
  end

endmodule

// File: hw/rv_exec_ctrl.sv
`timescale 1ns/1ps

module rv_exec_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              rd_we,
  input  logic              is_branch,
  input  logic              illegal,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     result,
  input  logic              taken,
  output logic              capture,
  output logic              ack,
  output logic              rf_we,
  output rv_pkg::reg_addr_t rf_waddr,
  output rv_pkg::word_t     rf_wdata,
  output rv_pkg::word_t     wb_data,
  output rv_pkg::reg_addr_t wb_rd,
  output logic              wb_en,
  output logic              br_taken,
  output logic              illegal_out
);

  rv_pkg::ctrl_state_e state;
  logic                wr_ok;

  // branches and illegal ops never write
  assign wr_ok = rd_we && !illegal && !is_branch;

  assign capture  = (state == rv_pkg::IDLE) && req;
  assign rf_we    = (state == rv_pkg::EXEC) && wr_ok; // lands at the edge into ACK
  assign rf_waddr = rd;
  assign rf_wdata = result;

  ////////////////////
  // handshake FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= rv_pkg::IDLE;
      ack         <= 1'b0;
      wb_data     <= '0;
      wb_rd       <= '0;
      wb_en       <= 1'b0;
      br_taken    <= 1'b0;
      illegal_out <= 1'b0;
    end else begin
      case (state)
        rv_pkg::IDLE: begin
          if (req) begin
            state <= rv_pkg::EXEC;                 // decoder captures this edge
          end
        end
        rv_pkg::EXEC: begin
          state       <= rv_pkg::ACK;
          ack         <= 1'b1;
          wb_data     <= wr_ok ? result : '0;      // zero when nothing is written
          wb_rd       <= wr_ok ? rd : '0;
          wb_en       <= wr_ok;
          br_taken    <= is_branch && !illegal && taken;
          illegal_out <= illegal;
        end
        rv_pkg::ACK: begin
          if (!req) begin
            state <= rv_pkg::IDLE;
            ack   <= 1'b0;                         // status held until here
          end
        end
        default: begin
          state <= rv_pkg::IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  a_ack_needs_req : assert property (
    @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req)
  ) else $error("ack rose without a pending req");

  a_write_in_exec : assert property (
    @(posedge clk) disable iff (rst) rf_we |-> $past(capture) && !ack
  ) else $error("register write without a capture the cycle before or while ack is high");

endmodule

// File: hw/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     instr,
  input  logic              req,
  output logic              ack,
  output rv_pkg::word_t     wb_data,
  output rv_pkg::reg_addr_t wb_rd,
  output logic              wb_en,
  output logic              br_taken,
  output logic              illegal
);

  logic              capture;
  rv_pkg::reg_addr_t dec_rs1;
  rv_pkg::reg_addr_t dec_rs2;
  rv_pkg::reg_addr_t dec_rd;
  rv_pkg::word_t     dec_imm;
  rv_pkg::alu_op_t   dec_alu_op;
  logic              dec_use_imm;
  logic              dec_rd_we;
  logic              dec_is_branch;
  rv_pkg::funct3_t   dec_br_funct3;
  logic              dec_illegal;
  rv_pkg::word_t     rd1;
  rv_pkg::word_t     rd2;
  rv_pkg::word_t     alu_result;
  logic              alu_taken;
  logic              rf_we;
  rv_pkg::reg_addr_t rf_waddr;
  rv_pkg::word_t     rf_wdata;

  rv_exec_ctrl rv_exec_ctrl_inst (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .rd_we       (dec_rd_we),
    .is_branch   (dec_is_branch),
    .illegal     (dec_illegal),
    .rd          (dec_rd),
    .result      (alu_result),
    .taken       (alu_taken),
    .capture     (capture),
    .ack         (ack),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .wb_data     (wb_data),
    .wb_rd       (wb_rd),
    .wb_en       (wb_en),
    .br_taken    (br_taken),
    .illegal_out (illegal)
  );

  rv_decoder rv_decoder_inst (
    .clk       (clk),
    .rst       (rst),
    .capture   (capture),
    .instr     (instr),
    .rs1       (dec_rs1),
    .rs2       (dec_rs2),
    .rd        (dec_rd),
    .imm       (dec_imm),
    .alu_op    (dec_alu_op),
    .use_imm   (dec_use_imm),
    .rd_we     (dec_rd_we),
    .is_branch (dec_is_branch),
    .br_funct3 (dec_br_funct3),
    .illegal   (dec_illegal)
  );

  rv_regfile rv_regfile_inst (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .rdata1 (rd1),
    .rdata2 (rd2)
  );

  rv_alu rv_alu_inst (
    .alu_op    (dec_alu_op),
    .use_imm   (dec_use_imm),
    .rd1       (rd1),
    .rd2       (rd2),
    .imm       (dec_imm),
    .br_funct3 (dec_br_funct3),
    .result    (alu_result),
    .taken     (alu_taken)
  );

endmodule

// File: dv/rv_exec_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec_tb;

  localparam int RESET_CYC = 8;
  localparam int N_RESET   = 1;
  localparam int N_HS      = 4;
  localparam int N_ITYPE   = 39;  // 15 fill + 24 random ops
  localparam int N_RTYPE   = 30;
  localparam int N_BRANCH  = 14;
  localparam int N_ILLEGAL = 19;  // 11 illegal + 8 read back
  localparam int N_TOTAL   = N_RESET + N_HS + N_ITYPE + N_RTYPE + N_BRANCH + N_ILLEGAL;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     instr;
  logic              req;
  logic              ack;
  rv_pkg::word_t     wb_data;
  rv_pkg::reg_addr_t wb_rd;
  logic              wb_en;
  logic              br_taken;
  logic              illegal;

  rv_pkg::word_t     shadow [`RV_NREGS];  // architectural register model
  rv_pkg::word_t     exp_data;
  rv_pkg::reg_addr_t exp_rd;
  logic              exp_en;
  logic              exp_tk;
  logic              exp_ill;
  int                err_cnt;
  int                tests_ok;
  int                tests_bad;
  int                resp_cnt = 0;

  rv_exec_top rv_exec_top_inst (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .req      (req),
    .ack      (ack),
    .wb_data  (wb_data),
    .wb_rd    (wb_rd),
    .wb_en    (wb_en),
    .br_taken (br_taken),
    .illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((RESET_CYC + N_TOTAL * 30) * 10);
    $display("watchdog expired, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////
  // checking and reference

  task automatic check_val(input rv_pkg::word_t got, input rv_pkg::word_t exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  function automatic rv_pkg::word_t alu_ref(input rv_pkg::funct3_t f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (f3)
      3'h0: r = alt ? a - b : a + b;
      3'h1: r = a << b[4:0];
      3'h2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'h3: r = (a < b) ? 32'd1 : 32'd0;
      3'h4: r = a ^ b;
      3'h5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];  // sign fill
        end else begin
          r = a >> b[4:0];
        end
      end
      3'h6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic void ref_exec(input rv_pkg::word_t ins, output rv_pkg::word_t e_data,
                                   output rv_pkg::reg_addr_t e_rd, output logic e_en,
                                   output logic e_tk, output logic e_ill);
    logic [6:0]      opc;
    rv_pkg::funct3_t f3;
    logic [6:0]      f7;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   immi;
    logic            wr;
    opc    = ins[6:0];
    f3     = ins[14:12];
    f7     = ins[31:25];
    a      = shadow[ins[19:15]];
    b      = shadow[ins[24:20]];
    immi   = {{20{ins[31]}}, ins[31:20]};
    e_data = '0;
    e_rd   = '0;
    e_en   = 1'b0;
    e_tk   = 1'b0;
    e_ill  = 1'b0;
    wr     = 1'b0;
    case (opc)
      `RV_OPC_OP: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'h0 || f3 == 3'h5))) begin
          e_data = alu_ref(f3, f7[5], a, b);
          wr     = 1'b1;
        end else begin
          e_ill = 1'b1;
        end
      end
      `RV_OPC_OPIMM: begin
        if (f3 == 3'h1 && f7 != 7'h00) begin
          e_ill = 1'b1;
        end else if (f3 == 3'h5 && f7 != 7'h00 && f7 != 7'h20) begin
          e_ill = 1'b1;
        end else begin
          e_data = alu_ref(f3, (f3 == 3'h5) && f7[5], a, immi);
          wr     = 1'b1;
        end
      end
      `RV_OPC_LUI: begin
        e_data = {ins[31:12], 12'h000};
        wr     = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        case (f3)
          3'h0: e_tk = (a == b);
          3'h1: e_tk = (a != b);
          3'h4: e_tk = ($signed(a) < $signed(b));
          3'h5: e_tk = !($signed(a) < $signed(b));
          3'h6: e_tk = (a < b);
          3'h7: e_tk = !(a < b);
          default: e_ill = 1'b1;
        endcase
      end
      default: e_ill = 1'b1;
    endcase
    if (wr) begin
      e_en = 1'b1;
      e_rd = ins[11:7];
    end else begin
      e_data = '0;
    end
  endfunction

  // response compare once per rising ack
  initial begin : resp_compare
    logic ack_prev;
    ack_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (ack && !ack_prev) begin
        resp_cnt++;
        check_val(32'(wb_en), 32'(exp_en), $sformatf("wb_en of %h", instr));
        if (exp_en) begin
          check_val(32'(wb_rd), 32'(exp_rd), $sformatf("wb_rd of %h", instr));
          check_val(wb_data, exp_data, $sformatf("wb_data of %h", instr));
        end
        check_val(32'(br_taken), 32'(exp_tk), $sformatf("br_taken of %h", instr));
        check_val(32'(illegal), 32'(exp_ill), $sformatf("illegal of %h", instr));
      end
      ack_prev = ack;
    end
  end

  ////////////////////
  // encoders and random helpers

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
                                          input rv_pkg::reg_addr_t rs1, input rv_pkg::funct3_t f3,
                                          input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
                                          input rv_pkg::funct3_t f3, input rv_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, `RV_OPC_OPIMM};
  endfunction

  function automatic rv_pkg::word_t enc_lui(input logic [19:0] imm, input rv_pkg::reg_addr_t rd);
    return {imm, rd, `RV_OPC_LUI};
  endfunction

  function automatic rv_pkg::word_t enc_b(input rv_pkg::funct3_t f3, input rv_pkg::reg_addr_t rs1,
                                          input rv_pkg::reg_addr_t rs2);
    return {7'h00, rs2, rs1, f3, 5'h08, `RV_OPC_BRANCH};  // fixed offset as there is no pc
  endfunction

  // the ten R-type ops by index
  function automatic rv_pkg::word_t enc_rop(input int k, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1,
                                            input rv_pkg::reg_addr_t rd);
    case (k)
      0:       return enc_r(7'h00, rs2, rs1, 3'h0, rd); // add
      1:       return enc_r(7'h20, rs2, rs1, 3'h0, rd); // sub
      2:       return enc_r(7'h00, rs2, rs1, 3'h4, rd); // xor
      3:       return enc_r(7'h00, rs2, rs1, 3'h6, rd); // or
      4:       return enc_r(7'h00, rs2, rs1, 3'h7, rd); // and
      5:       return enc_r(7'h00, rs2, rs1, 3'h1, rd); // sll
      6:       return enc_r(7'h00, rs2, rs1, 3'h5, rd); // srl
      7:       return enc_r(7'h20, rs2, rs1, 3'h5, rd); // sra
      8:       return enc_r(7'h00, rs2, rs1, 3'h2, rd); // slt
      default: return enc_r(7'h00, rs2, rs1, 3'h3, rd); // sltu
    endcase
  endfunction

  function automatic rv_pkg::reg_addr_t rand_reg(input int unsigned lo, input int unsigned hi);
    int unsigned r;
    r = $urandom_range(hi, lo);
    return r[4:0];
  endfunction

  function automatic logic [11:0] rand_imm12();
    int unsigned r;
    r = $urandom;
    return r[11:0];
  endfunction

  ////////////////////
  // handshake driver

  task automatic send_instr(input rv_pkg::word_t ins, input int hold);
    rv_pkg::word_t     e_data;
    rv_pkg::reg_addr_t e_rd;
    logic              e_en;
    logic              e_tk;
    logic              e_ill;
    rv_pkg::word_t     h_data;
    rv_pkg::reg_addr_t h_rd;
    logic              h_en;
    logic              h_tk;
    logic              h_ill;
    int                cycles;
    int                resp_before;
    ref_exec(ins, e_data, e_rd, e_en, e_tk, e_ill);
    exp_data    = e_data;
    exp_rd      = e_rd;
    exp_en      = e_en;
    exp_tk      = e_tk;
    exp_ill     = e_ill;
    resp_before = resp_cnt;
    @(posedge clk);
    #1;
    instr  = ins;
    req    = 1'b1;
    cycles = 0;
    while (!ack && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ack) begin
      $display("timeout: no ack within 20 cycles for instruction %h", ins);
      err_cnt++;
      req = 1'b0;
    end else begin
      check_val(32'(cycles), 32'd2, "ack latency in cycles");
      h_data = wb_data;
      h_rd   = wb_rd;
      h_en   = wb_en;
      h_tk   = br_taken;
      h_ill  = illegal;
      for (int i = 0; i < hold; i++) begin
        @(posedge clk);
        #1;
        check_val(32'(ack), 32'd1, "ack while req held");
        check_val(32'(rv_exec_top_inst.rf_we), 32'd0, "register write while req held");
        check_val(wb_data, h_data, "wb_data while ack high");
        check_val(32'(wb_rd), 32'(h_rd), "wb_rd while ack high");
        check_val(32'(wb_en), 32'(h_en), "wb_en while ack high");
        check_val(32'(br_taken), 32'(h_tk), "br_taken while ack high");
        check_val(32'(illegal), 32'(h_ill), "illegal while ack high");
      end
      req = 1'b0;
      @(posedge clk);
      #1;
      check_val(32'(ack), 32'd0, "ack one edge after req low");
      check_val(32'(resp_cnt - resp_before), 32'd1, "responses for one request");
      if (e_en && e_rd != '0) begin
        shadow[e_rd] = e_data;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_before);
    end
  endtask

  ////////////////////
  // tests

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    check_val(32'(ack), 32'd0, "ack after reset");
    check_val(32'(wb_en), 32'd0, "wb_en after reset");
    check_val(32'(br_taken), 32'd0, "br_taken after reset");
    check_val(32'(illegal), 32'd0, "illegal after reset");
    send_instr(enc_r(7'h00, 5'd2, 5'd1, 3'h0, 5'd3), 0);  // add x3, x1, x2
    finish_test("reset_state", e0);
  endtask

  task automatic test_handshake();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < N_HS; i++) begin
      send_instr(enc_i(rand_imm12(), rand_reg(0, 31), 3'h0, rand_reg(1, 31)),
                 $urandom_range(4, 1));
    end
    finish_test("handshake", e0);
  endtask

  task automatic test_itype();
    int              e0;
    rv_pkg::word_t   rnd;
    logic [11:0]     imm;
    rv_pkg::funct3_t f3;
    e0 = err_cnt;
    for (int r = 1; r <= 15; r++) begin
      rnd = $urandom;
      if (r == 14) begin
        send_instr(enc_lui({1'b1, rnd[18:0]}, 5'(r)), 0); // keep one negative source
      end else if (r % 2 == 1) begin
        send_instr(enc_lui(rnd[19:0], 5'(r)), 0);
      end else begin
        send_instr(enc_i(rnd[11:0], 5'(r - 1), 3'h0, 5'(r)), 0);
      end
    end
    for (int i = 0; i < N_ITYPE - 15; i++) begin
      rnd = $urandom;
      f3  = rnd[2:0];
      imm = rand_imm12();
      if (f3 == 3'h1) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'h5) begin
        imm[11:5] = rnd[3] ? 7'h20 : 7'h00;  // srai or srli
      end
      send_instr(enc_i(imm, rand_reg(0, 15), f3, rand_reg(1, 13)), 0);
    end
    finish_test("itype_ops", e0);
  endtask

  task automatic test_rtype();
    int                e0;
    rv_pkg::reg_addr_t rs1;
    e0 = err_cnt;
    for (int k = 0; k < 10; k++) begin
      for (int n = 0; n < 3; n++) begin
        rs1 = (n == 0) ? 5'd14 : rand_reg(0, 15);  // x14 is negative
        send_instr(enc_rop(k, rand_reg(0, 15), rs1, rand_reg(1, 13)), 0);
      end
    end
    finish_test("rtype_ops", e0);
  endtask

  task automatic test_branch();
    int                e0;
    rv_pkg::funct3_t   f3;
    rv_pkg::reg_addr_t rs;
    e0 = err_cnt;
    for (int k = 0; k < 6; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);  // 0,1,4,5,6,7
      rs = rand_reg(0, 15);
      send_instr(enc_b(f3, rs, rs), 0);
      send_instr(enc_b(f3, rand_reg(0, 15), rand_reg(0, 15)), 0);
    end
    send_instr(enc_i(rand_imm12() | 12'h001, 5'd1, 3'h0, 5'd0), 0);  // write aimed at x0
    send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'h0, 5'd0), 0);               // read x0 back
    finish_test("branch_and_x0", e0);
  endtask

  task automatic test_illegal();
    int            e0;
    rv_pkg::word_t rnd;
    logic [6:0]    opc [6];
    e0     = err_cnt;
    opc[0] = 7'h03;  // load
    opc[1] = 7'h23;  // store
    opc[2] = 7'h6f;  // jal
    opc[3] = 7'h67;  // jalr
    opc[4] = 7'h17;  // auipc
    opc[5] = 7'h73;  // system
    for (int i = 0; i < 6; i++) begin
      rnd = $urandom;
      send_instr({rnd[31:7], opc[i]}, 0);
    end
    send_instr(enc_i({7'h20, 5'd3}, 5'd2, 3'h1, 5'd4), 0);  // slli with bad funct7
    send_instr(enc_i({7'h10, 5'd7}, 5'd3, 3'h5, 5'd5), 0);  // srai with bad funct7
    send_instr(enc_r(7'h01, 5'd2, 5'd1, 3'h0, 5'd6), 0);    // mul is not kept
    send_instr(enc_b(3'h2, 5'd1, 5'd2), 0);
    send_instr(enc_b(3'h3, 5'd1, 5'd2), 0);
    for (int r = 1; r <= 8; r++) begin
      send_instr(enc_r(7'h00, 5'd0, 5'(r), 3'h0, 5'd0), 0);  // add x0, xr, x0 shows xr
    end
    finish_test("illegal", e0);
  endtask

  ////////////////////
  // main sequence

  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    instr     = '0;
    err_cnt   = 0;
    tests_ok  = 0;
    tests_bad = 0;
    exp_data  = '0;
    exp_rd    = '0;
    exp_en    = 1'b0;
    exp_tk    = 1'b0;
    exp_ill   = 1'b0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      shadow[i] = '0;
    end
    void'($urandom(32'heed));
    repeat (RESET_CYC) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset();
    test_handshake();
    test_itype();
    test_rtype();
    test_branch();
    test_illegal();

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_exec_ctrl.sv
hw/rv_exec_top.sv
dv/rv_exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BIN=rv_exec_sim
LOG=sim.log

verilator --binary --timing --assert \
  -f compile.f \
  --top-module rv_exec_tb \
  -Mdir "$BUILD_DIR" \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
